/* Bender.yml */
package:
  name: flight_ctrl

sources:
  - flight_pkg.sv
  - axis_cmd_if.sv
  - loop_timer.sv
  - loop_sequencer.sv
  - angle_controller.sv
  - rate_controller.sv
  - motor_mixer.sv
  - flight_ctrl_top.sv
  - target: test
    files:
      - tb_flight_ctrl.sv

/* angle_controller.sv */
`timescale 1ns/1ps

module angle_controller (
	input logic us_clk,
	input logic resetn,
	input logic start,
	input flight_pkg::stick_t throttle_stick,
	input flight_pkg::stick_t yaw_stick,
	input flight_pkg::stick_t pitch_stick,
	input flight_pkg::stick_t roll_stick,
	input flight_pkg::q12_4_t pitch_angle,
	input flight_pkg::q12_4_t roll_angle,
	axis_cmd_if.src cmd,
	output logic done
);

	// stick values scaled into Q12.4
	flight_pkg::q12_4_t throttle_map;
	flight_pkg::q12_4_t yaw_ctr;
	flight_pkg::q12_4_t pitch_ctr;
	flight_pkg::q12_4_t roll_ctr;

	// angle errors, one bit wider so a large IMU angle cannot wrap
	logic signed [16:0] pitch_err;
	logic signed [16:0] roll_err;

	// mapped values held between the two stages
	flight_pkg::q12_4_t throttle_q;
	flight_pkg::q12_4_t yaw_q;
	logic signed [16:0] pitch_q;
	logic signed [16:0] roll_q;
	logic map_vld;

	// throttle spans 0 to 62.5
	assign throttle_map = flight_pkg::q12_4_t'({6'b0, throttle_stick, 2'b00});

	// yaw, pitch and roll span -31.25 to 31.25
	assign yaw_ctr = flight_pkg::q12_4_t'({6'b0, yaw_stick, 2'b00})
		- flight_pkg::STICK_CENTER_RAW;
	assign pitch_ctr = flight_pkg::q12_4_t'({6'b0, pitch_stick, 2'b00})
		- flight_pkg::STICK_CENTER_RAW;
	assign roll_ctr = flight_pkg::q12_4_t'({6'b0, roll_stick, 2'b00})
		- flight_pkg::STICK_CENTER_RAW;

	// pitch target minus measured angle
	assign pitch_err = $signed({pitch_ctr[15], pitch_ctr})
		- $signed({pitch_angle[15], pitch_angle});
	// IMU roll sign is flipped, so the angle is added
	assign roll_err = $signed({roll_ctr[15], roll_ctr})
		+ $signed({roll_angle[15], roll_angle});

	// stage 1: register the mapped values on start
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_q <= '0;
			yaw_q <= '0;
			pitch_q <= '0;
			roll_q <= '0;
			map_vld <= 1'b0;
		end else begin
			map_vld <= start;
			if (start) begin
				throttle_q <= throttle_map;
				yaw_q <= yaw_ctr;
				pitch_q <= pitch_err;
				roll_q <= roll_err;
			end
		end
	end

	// stage 2: apply the rate limits and flag completion
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			cmd.throttle <= '0;
			cmd.yaw <= '0;
			cmd.pitch <= '0;
			cmd.roll <= '0;
			done <= 1'b0;
		end else begin
			done <= map_vld;
			if (map_vld) begin
				// throttle is never negative here, only the ceiling matters
				cmd.throttle <= flight_pkg::clamp_q($signed({{2{throttle_q[15]}}, throttle_q}),
					'0, flight_pkg::THROTTLE_MAX);
				cmd.yaw <= flight_pkg::clamp_q($signed({{2{yaw_q[15]}}, yaw_q}),
					-flight_pkg::ANGLE_RATE_MAX, flight_pkg::ANGLE_RATE_MAX);
				cmd.pitch <= flight_pkg::clamp_q($signed({pitch_q[16], pitch_q}),
					-flight_pkg::ANGLE_RATE_MAX, flight_pkg::ANGLE_RATE_MAX);
				cmd.roll <= flight_pkg::clamp_q($signed({roll_q[16], roll_q}),
					-flight_pkg::ANGLE_RATE_MAX, flight_pkg::ANGLE_RATE_MAX);
			end
		end
	end

endmodule

/* axis_cmd_if.sv */
`timescale 1ns/1ps

// four-axis command word passed from one control stage to the next
interface axis_cmd_if;

	// collective thrust
	flight_pkg::q12_4_t throttle;
	// rotation about the vertical axis
	flight_pkg::q12_4_t yaw;
	// nose up / nose down
	flight_pkg::q12_4_t pitch;
	// right side down / left side down
	flight_pkg::q12_4_t roll;

	// producing stage registers and drives the word
	modport src (
		output throttle,
		output yaw,
		output pitch,
		output roll
	);

	// consuming stage samples on its start strobe
	modport dst (
		input throttle,
		input yaw,
		input pitch,
		input roll
	);

endinterface

/* flight_ctrl_top.sv */
`timescale 1ns/1ps

module flight_ctrl_top (
	input logic us_clk,
	input logic resetn,
	input logic arm,
	input flight_pkg::stick_t throttle_stick,
	input flight_pkg::stick_t yaw_stick,
	input flight_pkg::stick_t pitch_stick,
	input flight_pkg::stick_t roll_stick,
	input flight_pkg::q12_4_t pitch_angle,
	input flight_pkg::q12_4_t roll_angle,
	input flight_pkg::q12_4_t yaw_gyro,
	input flight_pkg::q12_4_t pitch_gyro,
	input flight_pkg::q12_4_t roll_gyro,
	output flight_pkg::q12_4_t motor_0,
	output flight_pkg::q12_4_t motor_1,
	output flight_pkg::q12_4_t motor_2,
	output flight_pkg::q12_4_t motor_3,
	output logic motor_update,
	output logic busy
);

	// stage handshake strobes
	logic tick;
	logic angle_start;
	logic angle_done;
	logic rate_start;
	logic rate_done;
	logic mix_start;
	logic mix_done;

	// angle targets into the rate loop, then axis commands into the mixer
	axis_cmd_if angle_cmd ();
	axis_cmd_if axis_cmd ();

	loop_timer u_loop_timer (
		.us_clk (us_clk),
		.resetn (resetn),
		.arm    (arm),
		.tick   (tick)
	);

	loop_sequencer u_loop_sequencer (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.tick        (tick),
		.angle_done  (angle_done),
		.rate_done   (rate_done),
		.mix_done    (mix_done),
		.angle_start (angle_start),
		.rate_start  (rate_start),
		.mix_start   (mix_start),
		.busy        (busy)
	);

	angle_controller u_angle_controller (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.start          (angle_start),
		.throttle_stick (throttle_stick),
		.yaw_stick      (yaw_stick),
		.pitch_stick    (pitch_stick),
		.roll_stick     (roll_stick),
		.pitch_angle    (pitch_angle),
		.roll_angle     (roll_angle),
		.cmd            (angle_cmd.src),
		.done           (angle_done)
	);

	rate_controller u_rate_controller (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.start      (rate_start),
		.target     (angle_cmd.dst),
		.yaw_gyro   (yaw_gyro),
		.pitch_gyro (pitch_gyro),
		.roll_gyro  (roll_gyro),
		.cmd        (axis_cmd.src),
		.done       (rate_done)
	);

	motor_mixer u_motor_mixer (
		.us_clk  (us_clk),
		.resetn  (resetn),
		.start   (mix_start),
		.arm     (arm),
		.axis    (axis_cmd.dst),
		.motor_0 (motor_0),
		.motor_1 (motor_1),
		.motor_2 (motor_2),
		.motor_3 (motor_3),
		.done    (mix_done)
	);

	// new motor values are valid with the mixer's done strobe
	assign motor_update = mix_done;

endmodule

/* flight_pkg.sv */
package flight_pkg;

	// signed Q12.4 word used for every rate, angle, command and motor value
	typedef logic signed [15:0] q12_4_t;

	// raw receiver stick value, 0 to 250
	typedef logic [7:0] stick_t;

	// stick << 2 spans 0 to 62.5, this offset centres it on zero (31.25)
	localparam q12_4_t STICK_CENTER_RAW = 16'sd500;

	// throttle target ceiling, 60.0
	localparam q12_4_t THROTTLE_MAX = 16'sh03c0;

	// symmetric limit on yaw, pitch and roll target rates, 25.0
	localparam q12_4_t ANGLE_RATE_MAX = 16'sh0190;

	// proportional rate gain as a left shift, gain of 2
	localparam int RATE_KP_SHIFT = 1;

	// symmetric limit on the rate stage axis command, 128.0
	localparam q12_4_t AXIS_CMD_MAX = 16'sh0800;

	// motor command ceiling, floor is zero
	localparam q12_4_t MOTOR_MAX = 16'sh0fff;

	// us_clk cycles between control updates
	localparam int LOOP_PERIOD = 16;
	localparam int LOOP_CNT_W = $clog2(LOOP_PERIOD);

	// one-hot bit positions of the loop sequencer FSM
	localparam int SEQ_IDLE = 0;
	localparam int SEQ_ANGLE = 1;
	localparam int SEQ_RATE = 2;
	localparam int SEQ_MIX = 3;

	// saturate a wide intermediate into [lo, hi]
	function automatic q12_4_t clamp_q(input logic signed [17:0] val, input q12_4_t lo,
		input q12_4_t hi);
		if (val > hi)
			return hi;
		else if (val < lo)
			return lo;
		else
			return q12_4_t'(val[15:0]);
	endfunction

endpackage

/* loop_sequencer.sv */
`timescale 1ns/1ps

module loop_sequencer (
	input logic us_clk,
	input logic resetn,
	input logic tick,
	input logic angle_done,
	input logic rate_done,
	input logic mix_done,
	output logic angle_start,
	output logic rate_start,
	output logic mix_start,
	output logic busy
);

	// one-hot state, bit positions from the package
	logic [3:0] state;
	logic [3:0] state_nxt;

	// next state
	always_comb begin
		state_nxt = state;
		if (state[flight_pkg::SEQ_IDLE]) begin
			// a new loop begins only from idle
			if (tick)
				state_nxt = 4'b1 << flight_pkg::SEQ_ANGLE;
		end else if (state[flight_pkg::SEQ_ANGLE]) begin
			if (angle_done)
				state_nxt = 4'b1 << flight_pkg::SEQ_RATE;
		end else if (state[flight_pkg::SEQ_RATE]) begin
			if (rate_done)
				state_nxt = 4'b1 << flight_pkg::SEQ_MIX;
		end else if (state[flight_pkg::SEQ_MIX]) begin
			if (mix_done)
				state_nxt = 4'b1 << flight_pkg::SEQ_IDLE;
		end else begin
			// no bit set, recover to idle
			state_nxt = 4'b1 << flight_pkg::SEQ_IDLE;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= 4'b1 << flight_pkg::SEQ_IDLE;
			angle_start <= 1'b0;
			rate_start <= 1'b0;
			mix_start <= 1'b0;
		end else begin
			state <= state_nxt;
			// start strobes coincide with entry into each stage state
			angle_start <= state[flight_pkg::SEQ_IDLE] && tick;
			rate_start <= state[flight_pkg::SEQ_ANGLE] && angle_done;
			mix_start <= state[flight_pkg::SEQ_RATE] && rate_done;
		end
	end

	// high from angle_start through the mix_done cycle
	assign busy = !state[flight_pkg::SEQ_IDLE];

endmodule

/* loop_timer.sv */
`timescale 1ns/1ps

module loop_timer (
	input logic us_clk,
	input logic resetn,
	input logic arm,
	output logic tick
);

	// position inside the current loop period
	logic [flight_pkg::LOOP_CNT_W-1:0] count;
	logic wrap;

	// last cycle of the period
	assign wrap = (count == flight_pkg::LOOP_CNT_W'(flight_pkg::LOOP_PERIOD - 1));

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			count <= '0;
			tick <= 1'b0;
		end else begin
			// disarmed holds the counter so arming begins a full period
			if (!arm)
				count <= '0;
			else if (wrap)
				count <= '0;
			else
				count <= count + 1'b1;
			// registered pulse, one cycle wide, on each wrap
			tick <= arm && wrap;
		end
	end

endmodule

/* motor_mixer.sv */
`timescale 1ns/1ps

module motor_mixer (
	input logic us_clk,
	input logic resetn,
	input logic start,
	input logic arm,
	axis_cmd_if.dst axis,
	output flight_pkg::q12_4_t motor_0,
	output flight_pkg::q12_4_t motor_1,
	output flight_pkg::q12_4_t motor_2,
	output flight_pkg::q12_4_t motor_3,
	output logic done
);

	// axis commands sign-extended to 18 bits, four terms cannot overflow
	logic signed [17:0] thr_x;
	logic signed [17:0] yaw_x;
	logic signed [17:0] pitch_x;
	logic signed [17:0] roll_x;

	// raw quad-X sums before saturation
	logic signed [17:0] mix_0;
	logic signed [17:0] mix_1;
	logic signed [17:0] mix_2;
	logic signed [17:0] mix_3;

	assign thr_x = $signed({{2{axis.throttle[15]}}, axis.throttle});
	assign yaw_x = $signed({{2{axis.yaw[15]}}, axis.yaw});
	assign pitch_x = $signed({{2{axis.pitch[15]}}, axis.pitch});
	assign roll_x = $signed({{2{axis.roll[15]}}, axis.roll});

	// X layout, diagonal pairs spin the same way and share the yaw sign
	assign mix_0 = thr_x + pitch_x + roll_x - yaw_x;
	assign mix_1 = thr_x + pitch_x - roll_x + yaw_x;
	assign mix_2 = thr_x - pitch_x - roll_x - yaw_x;
	assign mix_3 = thr_x - pitch_x + roll_x + yaw_x;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_0 <= '0;
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
			done <= 1'b0;
		end else begin
			done <= start;
			if (!arm) begin
				// disarmed, motors stop regardless of the sequencer
				motor_0 <= '0;
				motor_1 <= '0;
				motor_2 <= '0;
				motor_3 <= '0;
			end else if (start) begin
				// motors cannot run backwards, floor at zero
				motor_0 <= flight_pkg::clamp_q(mix_0, '0, flight_pkg::MOTOR_MAX);
				motor_1 <= flight_pkg::clamp_q(mix_1, '0, flight_pkg::MOTOR_MAX);
				motor_2 <= flight_pkg::clamp_q(mix_2, '0, flight_pkg::MOTOR_MAX);
				motor_3 <= flight_pkg::clamp_q(mix_3, '0, flight_pkg::MOTOR_MAX);
			end
		end
	end

endmodule

/* rate_controller.sv */
`timescale 1ns/1ps

module rate_controller (
	input logic us_clk,
	input logic resetn,
	input logic start,
	axis_cmd_if.dst target,
	input flight_pkg::q12_4_t yaw_gyro,
	input flight_pkg::q12_4_t pitch_gyro,
	input flight_pkg::q12_4_t roll_gyro,
	axis_cmd_if.src cmd,
	output logic done
);

	// rate errors, 17 bits so target minus gyro never wraps
	logic signed [16:0] yaw_err;
	logic signed [16:0] pitch_err;
	logic signed [16:0] roll_err;
	flight_pkg::q12_4_t throttle_q;
	logic err_vld;

	// error times the proportional gain
	logic signed [17:0] yaw_gain;
	logic signed [17:0] pitch_gain;
	logic signed [17:0] roll_gain;

	// stage 1: target minus measured rate, sampled on start
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_err <= '0;
			pitch_err <= '0;
			roll_err <= '0;
			throttle_q <= '0;
			err_vld <= 1'b0;
		end else begin
			err_vld <= start;
			if (start) begin
				yaw_err <= $signed({target.yaw[15], target.yaw})
					- $signed({yaw_gyro[15], yaw_gyro});
				pitch_err <= $signed({target.pitch[15], target.pitch})
					- $signed({pitch_gyro[15], pitch_gyro});
				roll_err <= $signed({target.roll[15], target.roll})
					- $signed({roll_gyro[15], roll_gyro});
				// throttle has no rate loop
				throttle_q <= target.throttle;
			end
		end
	end

	// Kp as an arithmetic shift, one spare bit covers a gain of 2
	assign yaw_gain = $signed({yaw_err[16], yaw_err}) <<< flight_pkg::RATE_KP_SHIFT;
	assign pitch_gain = $signed({pitch_err[16], pitch_err}) <<< flight_pkg::RATE_KP_SHIFT;
	assign roll_gain = $signed({roll_err[16], roll_err}) <<< flight_pkg::RATE_KP_SHIFT;

	// stage 2: saturate to the axis command range
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			cmd.throttle <= '0;
			cmd.yaw <= '0;
			cmd.pitch <= '0;
			cmd.roll <= '0;
			done <= 1'b0;
		end else begin
			done <= err_vld;
			if (err_vld) begin
				cmd.throttle <= throttle_q;
				cmd.yaw <= flight_pkg::clamp_q(yaw_gain,
					-flight_pkg::AXIS_CMD_MAX, flight_pkg::AXIS_CMD_MAX);
				cmd.pitch <= flight_pkg::clamp_q(pitch_gain,
					-flight_pkg::AXIS_CMD_MAX, flight_pkg::AXIS_CMD_MAX);
				cmd.roll <= flight_pkg::clamp_q(roll_gain,
					-flight_pkg::AXIS_CMD_MAX, flight_pkg::AXIS_CMD_MAX);
			end
		end
	end

endmodule

/* tb_flight_ctrl.sv */
`timescale 1ns/1ps

module tb_flight_ctrl;

	// run length bound, one update per test plus slack for reset and arming
	localparam int TEST_COUNT = 40;
	localparam int TIMEOUT_CYCLES = TEST_COUNT * flight_pkg::LOOP_PERIOD
		+ 20 * flight_pkg::LOOP_PERIOD;
	// tick to motor_update latency through the three stages
	localparam int PIPE_DELAY = 8;

	logic us_clk;
	logic resetn;
	logic arm;
	flight_pkg::stick_t throttle_stick;
	flight_pkg::stick_t yaw_stick;
	flight_pkg::stick_t pitch_stick;
	flight_pkg::stick_t roll_stick;
	flight_pkg::q12_4_t pitch_angle;
	flight_pkg::q12_4_t roll_angle;
	flight_pkg::q12_4_t yaw_gyro;
	flight_pkg::q12_4_t pitch_gyro;
	flight_pkg::q12_4_t roll_gyro;
	flight_pkg::q12_4_t motor_0;
	flight_pkg::q12_4_t motor_1;
	flight_pkg::q12_4_t motor_2;
	flight_pkg::q12_4_t motor_3;
	logic motor_update;
	logic busy;

	integer seed;
	integer cycle_count;
	integer fail_count;

	flight_ctrl_top u_flight_ctrl_top (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.arm            (arm),
		.throttle_stick (throttle_stick),
		.yaw_stick      (yaw_stick),
		.pitch_stick    (pitch_stick),
		.roll_stick     (roll_stick),
		.pitch_angle    (pitch_angle),
		.roll_angle     (roll_angle),
		.yaw_gyro       (yaw_gyro),
		.pitch_gyro     (pitch_gyro),
		.roll_gyro      (roll_gyro),
		.motor_0        (motor_0),
		.motor_1        (motor_1),
		.motor_2        (motor_2),
		.motor_3        (motor_3),
		.motor_update   (motor_update),
		.busy           (busy)
	);

	// 100 ns clock
	initial begin
		us_clk = 1'b0;
		forever #50 us_clk = ~us_clk;
	end

	// watchdog on total clock cycles
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge us_clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped by the watchdog");
	end

	task automatic report_failure(input string msg);
		fail_count = fail_count + 1;
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_motor(input string name, input flight_pkg::q12_4_t exp,
		input flight_pkg::q12_4_t act);
		if (act !== exp)
			report_failure($sformatf("** Error: %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_cycles(input string name, input integer exp, input integer act);
		if (act !== exp)
			report_failure($sformatf("** Error: %s expected %h got %h", name, exp, act));
	endtask

	function automatic integer saturate(input integer val, input integer lo, input integer hi);
		if (val > hi)
			return hi;
		if (val < lo)
			return lo;
		return val;
	endfunction

	// reference model, angle stage then rate stage then quad-X mix
	task automatic expected_motors(output flight_pkg::q12_4_t m0, output flight_pkg::q12_4_t m1,
		output flight_pkg::q12_4_t m2, output flight_pkg::q12_4_t m3);
		integer center;
		integer amax;
		integer cmax;
		integer thr;
		integer yaw_c;
		integer pitch_c;
		integer roll_c;
		center = integer'(flight_pkg::STICK_CENTER_RAW);
		amax = integer'(flight_pkg::ANGLE_RATE_MAX);
		cmax = integer'(flight_pkg::AXIS_CMD_MAX);
		// target rates from the sticks, pitch angle subtracted and roll angle added
		thr = saturate(integer'(throttle_stick) * 4, 0, integer'(flight_pkg::THROTTLE_MAX));
		yaw_c = saturate(integer'(yaw_stick) * 4 - center, -amax, amax);
		pitch_c = saturate(integer'(pitch_stick) * 4 - center - integer'(pitch_angle),
			-amax, amax);
		roll_c = saturate(integer'(roll_stick) * 4 - center + integer'(roll_angle), -amax, amax);
		// proportional gain of two on the rate error
		yaw_c = saturate((yaw_c - integer'(yaw_gyro)) * 2, -cmax, cmax);
		pitch_c = saturate((pitch_c - integer'(pitch_gyro)) * 2, -cmax, cmax);
		roll_c = saturate((roll_c - integer'(roll_gyro)) * 2, -cmax, cmax);
		m0 = flight_pkg::q12_4_t'(saturate(thr + pitch_c + roll_c - yaw_c, 0, 4095));
		m1 = flight_pkg::q12_4_t'(saturate(thr + pitch_c - roll_c + yaw_c, 0, 4095));
		m2 = flight_pkg::q12_4_t'(saturate(thr - pitch_c - roll_c - yaw_c, 0, 4095));
		m3 = flight_pkg::q12_4_t'(saturate(thr - pitch_c + roll_c + yaw_c, 0, 4095));
	endtask

	// returns at the falling edge where motor_update is high
	task automatic wait_update();
		@(negedge us_clk);
		while (motor_update !== 1'b1)
			@(negedge us_clk);
	endtask

	task automatic set_inputs(input flight_pkg::stick_t thr, input flight_pkg::stick_t yaw,
		input flight_pkg::stick_t pitch, input flight_pkg::stick_t roll,
		input flight_pkg::q12_4_t pa, input flight_pkg::q12_4_t ra,
		input flight_pkg::q12_4_t yg, input flight_pkg::q12_4_t pg, input flight_pkg::q12_4_t rg);
		throttle_stick = thr;
		yaw_stick = yaw;
		pitch_stick = pitch;
		roll_stick = roll;
		pitch_angle = pa;
		roll_angle = ra;
		yaw_gyro = yg;
		pitch_gyro = pg;
		roll_gyro = rg;
	endtask

	// inputs are applied just after an update, so the next loop sees all of them
	task automatic check_motors_now(input string label);
		flight_pkg::q12_4_t e0;
		flight_pkg::q12_4_t e1;
		flight_pkg::q12_4_t e2;
		flight_pkg::q12_4_t e3;
		expected_motors(e0, e1, e2, e3);
		check_motor({label, " motor_0"}, e0, motor_0);
		check_motor({label, " motor_1"}, e1, motor_1);
		check_motor({label, " motor_2"}, e2, motor_2);
		check_motor({label, " motor_3"}, e3, motor_3);
	endtask

	task automatic run_and_check(input string label);
		wait_update();
		check_motors_now(label);
	endtask

	task automatic test_hover();
		set_inputs(8'd125, 8'd125, 8'd125, 8'd125, '0, '0, '0, '0, '0);
		run_and_check("hover");
		// no attitude contribution, every motor is throttle << 2
		check_motor("hover motor_0", 16'sd500, motor_0);
		check_motor("hover motor_1", 16'sd500, motor_1);
		check_motor("hover motor_2", 16'sd500, motor_2);
		check_motor("hover motor_3", 16'sd500, motor_3);
	endtask

	task automatic test_angle();
		// inside the limits, shows pitch minus angle and roll plus angle
		set_inputs(8'd150, 8'd125, 8'd200, 8'd125, 16'sh0040, 16'sh0030, '0, '0, '0);
		run_and_check("angle error");
		// full throttle and both angle targets pushed past 25.0
		set_inputs(8'd250, 8'd125, 8'd250, 8'd0, -16'sh0040, -16'sh0030, '0, '0, '0);
		run_and_check("angle clamp");
	endtask

	task automatic test_rate();
		// doubled errors exceed 128.0 in both directions
		set_inputs(8'd200, 8'd250, 8'd0, 8'd125, '0, '0, -16'sh0400, 16'sh0500, 16'sh0600);
		run_and_check("rate clamp");
	endtask

	task automatic test_saturation();
		set_inputs(8'd10, 8'd125, 8'd250, 8'd250, '0, '0, '0, '0, '0);
		run_and_check("motor floor");
		check_motor("floor motor_2", '0, motor_2);
		set_inputs(8'd250, 8'd0, 8'd250, 8'd250, '0, '0, 16'sh0800, -16'sh0800, -16'sh0800);
		run_and_check("motor ceiling");
		check_motor("ceiling motor_0", flight_pkg::MOTOR_MAX, motor_0);
	endtask

	task automatic test_random();
		repeat (30) begin
			set_inputs(flight_pkg::stick_t'($unsigned($random(seed)) % 251),
				flight_pkg::stick_t'($unsigned($random(seed)) % 251),
				flight_pkg::stick_t'($unsigned($random(seed)) % 251),
				flight_pkg::stick_t'($unsigned($random(seed)) % 251),
				flight_pkg::q12_4_t'($random(seed)), flight_pkg::q12_4_t'($random(seed)),
				flight_pkg::q12_4_t'($random(seed)), flight_pkg::q12_4_t'($random(seed)),
				flight_pkg::q12_4_t'($random(seed)));
			run_and_check("random");
		end
	endtask

	task automatic test_timing();
		integer count;
		integer busy_count;
		// period between two updates, busy counted over the same loop
		count = 0;
		busy_count = 0;
		do begin
			@(negedge us_clk);
			count = count + 1;
			if (busy === 1'b1)
				busy_count = busy_count + 1;
		end while (motor_update !== 1'b1);
		check_cycles("update period", flight_pkg::LOOP_PERIOD, count);
		// busy from the cycle after the tick through the update cycle
		check_cycles("busy cycles", PIPE_DELAY, busy_count);
		if (busy !== 1'b1)
			report_failure("busy was low in the cycle of motor_update");
		// disarm right after an update while the sequencer is idle
		arm = 1'b0;
		repeat (3 * flight_pkg::LOOP_PERIOD) begin
			@(negedge us_clk);
			if (motor_update)
				report_failure("motor_update pulsed while the craft was disarmed");
		end
		check_motor("disarmed motor_0", '0, motor_0);
		check_motor("disarmed motor_1", '0, motor_1);
		check_motor("disarmed motor_2", '0, motor_2);
		check_motor("disarmed motor_3", '0, motor_3);
		// re-arm, first update after a full period plus the pipeline
		arm = 1'b1;
		count = 0;
		do begin
			@(negedge us_clk);
			count = count + 1;
		end while (motor_update !== 1'b1);
		check_cycles("first update after arm", flight_pkg::LOOP_PERIOD + PIPE_DELAY, count);
		check_motors_now("re-armed");
	endtask

	initial begin
		seed = 32'hc13c2356;
		fail_count = 0;
		resetn = 1'b0;
		arm = 1'b0;
		set_inputs('0, '0, '0, '0, '0, '0, '0, '0, '0);
		repeat (3) @(negedge us_clk);
		resetn = 1'b1;
		check_motor("reset motor_0", '0, motor_0);
		check_motor("reset motor_3", '0, motor_3);
		if (motor_update || busy)
			report_failure("motor_update or busy is high right after reset");
		// arm and let the first loop complete before the checks begin
		arm = 1'b1;
		wait_update();
		test_hover();
		test_angle();
		test_rate();
		test_saturation();
		test_random();
		test_timing();
		if (fail_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* vlog.f */
flight_pkg.sv
axis_cmd_if.sv
loop_timer.sv
loop_sequencer.sv
angle_controller.sv
rate_controller.sv
motor_mixer.sv
flight_ctrl_top.sv
tb_flight_ctrl.sv
